// ==== bench/lsu_chk.sv ====
`default_nettype none

module lsu_chk import lsu_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic [3:0]            wb_sel,
    input logic [XLEN-1:0]       wb_adr,
    input logic [XLEN-1:0]       wb_wdata,
    input logic                  wb_ack,
    input logic                  done_valid,
    input logic                  done_ready,
    input logic [TAG_W-1:0]      done_tag,
    input logic [REG_ADDR_W-1:0] done_dest,
    input logic                  done_we,
    input logic [XLEN-1:0]       done_result,
    input logic                  done_ex,
    input logic [EXCCODE_W-1:0]  done_exccode,
    input logic [XLEN-1:0]       done_badvaddr
);

    a_stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request fields frozen until the slave acks
    a_request_held: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_we) && $stable(wb_sel)
                                 && $stable(wb_adr) && $stable(wb_wdata)))
        else $error("wishbone request changed before ack");

    // classic cycle ends right after ack
    a_cycle_ends: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
        else $error("wishbone cycle still open after ack");

    a_done_held: assert property (@(posedge clk) disable iff (reset)
        (done_valid && !done_ready) |=> (done_valid && $stable(done_tag) && $stable(done_dest)
            && $stable(done_we) && $stable(done_result) && $stable(done_ex)
            && $stable(done_exccode) && $stable(done_badvaddr)))
        else $error("completion changed while done_ready was low");

endmodule

bind lsu_top lsu_chk u_lsu_chk (
    .clk           (clk),
    .reset         (reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_sel        (wb_sel),
    .wb_adr        (wb_adr),
    .wb_wdata      (wb_wdata),
    .wb_ack        (wb_ack),
    .done_valid    (done_valid),
    .done_ready    (done_ready),
    .done_tag      (done_tag),
    .done_dest     (done_dest),
    .done_we       (done_we),
    .done_result   (done_result),
    .done_ex       (done_ex),
    .done_exccode  (done_exccode),
    .done_badvaddr (done_badvaddr)
);

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  issue_valid = 1'b0;
    logic                  issue_ready;
    logic [OP_W-1:0]       issue_op = OP_NOP;
    logic [XLEN-1:0]       issue_base = '0;
    logic [15:0]           issue_offset = '0;
    logic [XLEN-1:0]       issue_rt = '0;
    logic [REG_ADDR_W-1:0] issue_dest = '0;
    logic [TAG_W-1:0]      issue_tag = '0;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [3:0]            wb_sel;
    logic [XLEN-1:0]       wb_adr;
    logic [XLEN-1:0]       wb_wdata;
    logic                  wb_ack = 1'b0;
    logic [XLEN-1:0]       wb_rdata = '0;
    logic                  done_valid;
    logic                  done_ready = 1'b0;
    logic [TAG_W-1:0]      done_tag;
    logic [REG_ADDR_W-1:0] done_dest;
    logic                  done_we;
    logic [XLEN-1:0]       done_result;
    logic                  done_ex;
    logic [EXCCODE_W-1:0]  done_exccode;
    logic [XLEN-1:0]       done_badvaddr;

    logic [XLEN-1:0] mem    [256];
    logic [XLEN-1:0] shadow [256];
    int wait_left = 0;
    int bus_cycles = 0;
    int exp_cycles = 0;
    int check_errors = 0;
    int flow_errors = 0;
    logic [TAG_W-1:0] next_tag = '0;

    // one entry per issued instruction in issue order
    logic [31:0] exp_tag[$];
    logic [31:0] exp_dest[$];
    logic [31:0] exp_we[$];
    logic [31:0] exp_result[$];
    logic [31:0] exp_ex[$];
    logic [31:0] exp_code[$];
    logic [31:0] exp_bad[$];

    logic [OP_W-1:0] load_ops [7] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    logic [OP_W-1:0] store_ops [5] = '{OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};

    lsu_top UUT (.*);

    always #20 clk = ~clk;

    // expected load value built lane by lane
    function automatic logic [31:0] load_result(input logic [OP_W-1:0] op, input logic [1:0] k,
                                                input logic [31:0] word, input logic [31:0] rt);
        logic [7:0]  b8;
        logic [15:0] h16;
        logic [31:0] r;
        int sh;
        b8  = word[8*k +: 8];
        h16 = word[16*k[1] +: 16];
        sh  = 3 - int'(k);
        r   = word;
        case (op)
            OP_LB:  r = {{24{b8[7]}}, b8};
            OP_LBU: r = {24'h0, b8};
            OP_LH:  r = {{16{h16[15]}}, h16};
            OP_LHU: r = {16'h0, h16};
            // memory lanes 0..k land in the top bytes
            OP_LWL: begin
                for (int j = 0; j < 4; j++)
                    r[8*j +: 8] = (j >= sh) ? word[8*(j-sh) +: 8] : rt[8*j +: 8];
            end
            // memory lanes k..3 land in the bottom bytes
            OP_LWR: begin
                for (int j = 0; j < 4; j++)
                    r[8*j +: 8] = (j <= sh) ? word[8*(j+int'(k)) +: 8] : rt[8*j +: 8];
            end
            default: r = word;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] store_word(input logic [OP_W-1:0] op, input logic [1:0] k,
                                               input logic [31:0] old, input logic [31:0] rt);
        logic [31:0] r;
        int kk;
        r  = old;
        kk = int'(k);
        case (op)
            OP_SB: r[8*kk +: 8] = rt[7:0];
            OP_SH: r[16*k[1] +: 16] = rt[15:0];
            OP_SW: r = rt;
            OP_SWL: begin
                for (int j = 0; j <= kk; j++)
                    r[8*j +: 8] = rt[8*(j+3-kk) +: 8];
            end
            OP_SWR: begin
                for (int j = kk; j < 4; j++)
                    r[8*j +: 8] = rt[8*(j-kk) +: 8];
            end
            default: r = old;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int count);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d in completion checks, %0d in run control",
                 check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    // called just after a rising edge and returns on the edge that takes the instruction
    task automatic issue(input logic [OP_W-1:0] op, input logic [31:0] base,
                         input logic [15:0] offset, input logic [31:0] rt);
        logic [31:0] addr;
        logic [7:0]  idx;
        logic [4:0]  dest;
        logic        store;
        logic        bad;
        logic        we;
        logic [31:0] result;
        int cycles;
        addr   = base + {{16{offset[15]}}, offset};
        idx    = addr[9:2];
        dest   = 5'($urandom_range(0, 31));
        store  = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
        bad    = ((op == OP_LH || op == OP_LHU || op == OP_SH) && addr[0])
              || ((op == OP_LW || op == OP_SW) && addr[1:0] != 2'd0);
        we     = 1'b0;
        result = '0;
        if (!bad && store) begin
            shadow[idx] = store_word(op, addr[1:0], shadow[idx], rt);
            exp_cycles++;
        end else if (!bad) begin
            result = load_result(op, addr[1:0], shadow[idx], rt);
            we     = 1'b1;
            exp_cycles++;
        end
        exp_tag.push_back(32'(next_tag));
        exp_dest.push_back(32'(dest));
        exp_we.push_back(32'(we));
        exp_result.push_back(result);
        exp_ex.push_back(32'(bad));
        exp_code.push_back(store ? 32'(EXC_ADES) : 32'(EXC_ADEL));
        exp_bad.push_back(addr);

        issue_valid  <= 1'b1;
        issue_op     <= op;
        issue_base   <= base;
        issue_offset <= offset;
        issue_rt     <= rt;
        issue_dest   <= dest;
        issue_tag    <= next_tag;
        next_tag = next_tag + 4'd1;

        cycles = 0;
        @(negedge clk);
        while (!issue_ready && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (!issue_ready) begin
            $display("timeout: issue_ready stayed low for %0d cycles", WAIT_LIMIT);
            flow_errors++;
        end
        @(posedge clk);
    endtask

    // memory slave with 0 to 3 wait cycles per access
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_left == 0) begin
                wb_ack     <= 1'b1;
                wb_rdata   <= mem[wb_adr[9:2]];
                bus_cycles <= bus_cycles + 1;
                wait_left  <= $urandom_range(0, 3);
                for (int i = 0; i < 4; i++)
                    if (wb_we && wb_sel[i])
                        mem[wb_adr[9:2]][8*i +: 8] <= wb_wdata[8*i +: 8];
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk)
        done_ready <= ($urandom_range(0, 3) != 0);

    // a transfer takes place at the next rising edge
    always @(negedge clk) begin
        logic [31:0] ex_exp;
        logic [31:0] code_exp;
        logic [31:0] bad_exp;
        if (!reset && done_valid && done_ready) begin
            if (exp_tag.size() == 0) begin
                $display("completion with tag %h arrived with nothing outstanding", done_tag);
                check_errors++;
            end else begin
                ex_exp   = exp_ex.pop_front();
                code_exp = exp_code.pop_front();
                bad_exp  = exp_bad.pop_front();
                check_value("done_tag", 32'(done_tag), exp_tag.pop_front(), check_errors);
                check_value("done_dest", 32'(done_dest), exp_dest.pop_front(), check_errors);
                check_value("done_we", 32'(done_we), exp_we.pop_front(), check_errors);
                check_value("done_result", done_result, exp_result.pop_front(), check_errors);
                check_value("done_ex", 32'(done_ex), ex_exp, check_errors);
                if (ex_exp[0]) begin
                    check_value("done_exccode", 32'(done_exccode), code_exp, check_errors);
                    check_value("done_badvaddr", done_badvaddr, bad_exp, check_errors);
                end
            end
        end
    end

    initial begin
        logic [31:0] base;
        int cycles;
        void'($urandom(32'h0742_cd52));
        for (int i = 0; i < 256; i++) begin
            mem[i] <= {~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd17, i[7:0]};
            shadow[i] = {~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd17, i[7:0]};
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // every load at every lane through negative offsets
        // misaligned ones raise AdEL
        for (int w = 0; w < 3; w++)
            for (int k = 0; k < 4; k++)
                foreach (load_ops[n])
                    issue(load_ops[n], 32'h210 + 32'(4 * w), 16'hfff0 + 16'(k), $urandom);

        // each store into a fresh word and read back with LW
        foreach (store_ops[s])
            for (int k = 0; k < 4; k++) begin
                base = 32'h300 + 32'(16 * s + 4 * k);
                issue(store_ops[s], base, 16'(k), $urandom);
                issue(OP_LW, base, 16'h0000, $urandom);
            end

        // random mix over a small window so loads see earlier stores
        for (int n = 0; n < 80; n++)
            issue(4'($urandom_range(1, 12)), 32'h0000_0100,
                  16'($urandom_range(0, 63)) - 16'd32, $urandom);
        issue_valid <= 1'b0;

        cycles = 0;
        while (exp_tag.size() != 0 && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        if (exp_tag.size() != 0) begin
            $display("timeout: %0d completions still outstanding", exp_tag.size());
            flow_errors++;
        end
        // any late completion in this quiet window is an extra one
        repeat (20) @(posedge clk);
        check_value("bus_cycles", 32'(bus_cycles), 32'(exp_cycles), flow_errors);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/lsu_pkg.sv
rtl/load_align.sv
rtl/addr_queue.sv
rtl/addr_gen.sv
rtl/bus_master.sv
rtl/result_stage.sv
rtl/lsu_top.sv
bench/lsu_chk.sv
bench/lsu_tb.sv

// ==== rtl/addr_gen.sv ====
`default_nettype none

module addr_gen import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  q_valid,
    output logic                  q_ready,
    input  logic [OP_W-1:0]       q_op,
    input  logic [XLEN-1:0]       q_base,
    input  logic [XLEN-1:0]       q_offset_ext,
    input  logic [XLEN-1:0]       q_rt,
    input  logic [REG_ADDR_W-1:0] q_dest,
    input  logic [TAG_W-1:0]      q_tag,
    output logic                  ag_valid,
    input  logic                  ag_ready,
    output logic [OP_W-1:0]       ag_op,
    output logic [XLEN-1:0]       ag_addr,
    output logic [3:0]            ag_sel,
    output logic [XLEN-1:0]       ag_wdata,
    output logic [XLEN-1:0]       ag_rt,
    output logic [REG_ADDR_W-1:0] ag_dest,
    output logic [TAG_W-1:0]      ag_tag,
    output logic                  ag_ex,
    output logic [EXCCODE_W-1:0]  ag_exccode
);

    logic [XLEN-1:0] eff_addr;
    logic [1:0]      swl_shift;
    logic            is_store;
    logic            addr_err;
    logic [3:0]      sel_n;
    logic [XLEN-1:0] wdata_n;

    assign eff_addr  = q_base + q_offset_ext;
    assign swl_shift = 2'd3 - eff_addr[1:0];
    assign is_store  = q_op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    assign q_ready   = !ag_valid || ag_ready;

    // lane strobes and lane-aligned store data, loads read the whole word
    always_comb begin
        addr_err = 1'b0;
        sel_n    = 4'hf;
        wdata_n  = q_rt;
        case (q_op)
            OP_LH, OP_LHU: addr_err = eff_addr[0];
            OP_LW:         addr_err = |eff_addr[1:0];
            OP_SB: begin
                sel_n   = 4'b0001 << eff_addr[1:0];
                wdata_n = {4{q_rt[7:0]}};
            end
            OP_SH: begin
                addr_err = eff_addr[0];
                sel_n    = eff_addr[1] ? 4'b1100 : 4'b0011;
                wdata_n  = {2{q_rt[15:0]}};
            end
            OP_SW:  addr_err = |eff_addr[1:0];
            // high bytes of rt go to lane 0 up to the addressed lane
            OP_SWL: begin
                sel_n   = 4'b1111 >> swl_shift;
                wdata_n = q_rt >> {swl_shift, 3'b000};
            end
            OP_SWR: begin
                sel_n   = 4'b1111 << eff_addr[1:0];
                wdata_n = q_rt << {eff_addr[1:0], 3'b000};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            ag_valid <= 1'b0;
        else if (q_ready)
            ag_valid <= q_valid;
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            ag_op      <= q_op;
            ag_addr    <= eff_addr;
            ag_sel     <= sel_n;
            ag_wdata   <= wdata_n;
            ag_rt      <= q_rt;
            ag_dest    <= q_dest;
            ag_tag     <= q_tag;
            ag_ex      <= addr_err;
            ag_exccode <= !addr_err ? '0 : (is_store ? EXC_ADES : EXC_ADEL);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/addr_queue.sv ====
`default_nettype none

module addr_queue import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  logic [OP_W-1:0]       issue_op,
    input  logic [XLEN-1:0]       issue_base,
    input  logic [15:0]           issue_offset,
    input  logic [XLEN-1:0]       issue_rt,
    input  logic [REG_ADDR_W-1:0] issue_dest,
    input  logic [TAG_W-1:0]      issue_tag,
    output logic                  q_valid,
    input  logic                  q_ready,
    output logic [OP_W-1:0]       q_op,
    output logic [XLEN-1:0]       q_base,
    output logic [XLEN-1:0]       q_offset_ext,
    output logic [XLEN-1:0]       q_rt,
    output logic [REG_ADDR_W-1:0] q_dest,
    output logic [TAG_W-1:0]      q_tag
);

    // busy: output register only, full1/full2: plus one or two side entries
    enum logic [1:0] {Q_EMPTY, Q_BUSY, Q_FULL1, Q_FULL2} state, state_next;

    logic push, pop;
    logic out_we, buf_we, use_buf;
    logic head, tail;
    logic [XLEN-1:0] offset_ext;

    logic [OP_W-1:0]       buf_op     [2];
    logic [XLEN-1:0]       buf_base   [2];
    logic [XLEN-1:0]       buf_offset [2];
    logic [XLEN-1:0]       buf_rt     [2];
    logic [REG_ADDR_W-1:0] buf_dest   [2];
    logic [TAG_W-1:0]      buf_tag    [2];

    assign offset_ext  = {{(XLEN-16){issue_offset[15]}}, issue_offset};
    assign q_valid     = state != Q_EMPTY;
    assign issue_ready = state != Q_FULL2;
    assign push        = issue_valid && issue_ready;
    assign pop         = q_valid && q_ready;

    assign out_we  = (state == Q_EMPTY && push) || (state == Q_BUSY && push && pop)
                  || (state == Q_FULL1 && pop) || (state == Q_FULL2 && pop);
    assign buf_we  = (state == Q_BUSY && push && !pop) || (state == Q_FULL1 && push);
    // oldest waiting entry sits in the side buffer once it is non-empty
    assign use_buf = (state == Q_FULL1 || state == Q_FULL2) && pop;

    always_comb begin
        unique case (state)
            Q_EMPTY: state_next = push ? Q_BUSY : Q_EMPTY;
            Q_BUSY:  state_next = push ? (pop ? Q_BUSY : Q_FULL1) : (pop ? Q_EMPTY : Q_BUSY);
            Q_FULL1: state_next = push ? (pop ? Q_FULL1 : Q_FULL2) : (pop ? Q_BUSY : Q_FULL1);
            Q_FULL2: state_next = pop ? Q_FULL1 : Q_FULL2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Q_EMPTY;
            head  <= 1'b0;
            tail  <= 1'b0;
        end else begin
            state <= state_next;
            if (use_buf)
                head <= ~head;
            if (buf_we)
                tail <= ~tail;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            buf_op[tail]     <= issue_op;
            buf_base[tail]   <= issue_base;
            buf_offset[tail] <= offset_ext;
            buf_rt[tail]     <= issue_rt;
            buf_dest[tail]   <= issue_dest;
            buf_tag[tail]    <= issue_tag;
        end
        if (out_we) begin
            q_op         <= use_buf ? buf_op[head]     : issue_op;
            q_base       <= use_buf ? buf_base[head]   : issue_base;
            q_offset_ext <= use_buf ? buf_offset[head] : offset_ext;
            q_rt         <= use_buf ? buf_rt[head]     : issue_rt;
            q_dest       <= use_buf ? buf_dest[head]   : issue_dest;
            q_tag        <= use_buf ? buf_tag[head]    : issue_tag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_master.sv ====
`default_nettype none

module bus_master import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ag_valid,
    output logic                  ag_ready,
    input  logic [OP_W-1:0]       ag_op,
    input  logic [XLEN-1:0]       ag_addr,
    input  logic [3:0]            ag_sel,
    input  logic [XLEN-1:0]       ag_wdata,
    input  logic [XLEN-1:0]       ag_rt,
    input  logic [REG_ADDR_W-1:0] ag_dest,
    input  logic [TAG_W-1:0]      ag_tag,
    input  logic                  ag_ex,
    input  logic [EXCCODE_W-1:0]  ag_exccode,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [3:0]            wb_sel,
    output logic [XLEN-1:0]       wb_adr,
    output logic [XLEN-1:0]       wb_wdata,
    input  logic                  wb_ack,
    input  logic [XLEN-1:0]       wb_rdata,
    output logic                  bm_valid,
    input  logic                  bm_ready,
    output logic [OP_W-1:0]       bm_op,
    output logic [XLEN-1:0]       bm_addr,
    output logic [XLEN-1:0]       bm_rt,
    output logic [XLEN-1:0]       bm_rdata,
    output logic [REG_ADDR_W-1:0] bm_dest,
    output logic [TAG_W-1:0]      bm_tag,
    output logic                  bm_ex,
    output logic [EXCCODE_W-1:0]  bm_exccode
);

    enum logic [1:0] {BM_IDLE, BM_BUS, BM_HOLD} state;

    assign ag_ready = state == BM_IDLE;
    assign bm_valid = state == BM_HOLD;

    // request fields come straight from the held item, so they stay put until ack
    assign wb_cyc = state == BM_BUS;
    assign wb_stb = state == BM_BUS;
    assign wb_we  = bm_op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    assign wb_adr = {bm_addr[XLEN-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BM_IDLE;
        end else begin
            unique case (state)
                BM_IDLE: if (ag_valid) state <= ag_ex ? BM_HOLD : BM_BUS;
                BM_BUS:  if (wb_ack) state <= BM_HOLD;
                BM_HOLD: if (bm_ready) state <= BM_IDLE;
                default: state <= BM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ag_valid && ag_ready) begin
            bm_op      <= ag_op;
            bm_addr    <= ag_addr;
            wb_sel     <= ag_sel;
            wb_wdata   <= ag_wdata;
            bm_rt      <= ag_rt;
            bm_dest    <= ag_dest;
            bm_tag     <= ag_tag;
            bm_ex      <= ag_ex;
            bm_exccode <= ag_exccode;
        end
        if (state == BM_BUS && wb_ack)
            bm_rdata <= wb_rdata;
    end

endmodule

`default_nettype wire

// ==== rtl/load_align.sv ====
`default_nettype none

module load_align import lsu_pkg::*; (
    input  logic [OP_W-1:0] op,
    input  logic [1:0]      addr_low,
    input  logic [XLEN-1:0] rdata,
    input  logic [XLEN-1:0] rt,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] shifted;
    logic [7:0]      byte_val;
    logic [15:0]     half_val;
    logic [XLEN-1:0] lwl_val;
    logic [XLEN-1:0] lwr_val;

    // addressed lane moved down to bit 0
    assign shifted  = rdata >> {addr_low, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    // lwl fills the top from lane 0 upwards, rt keeps the rest
    always_comb begin
        case (addr_low)
            2'd0:    lwl_val = {rdata[7:0], rt[23:0]};
            2'd1:    lwl_val = {rdata[15:0], rt[15:0]};
            2'd2:    lwl_val = {rdata[23:0], rt[7:0]};
            default: lwl_val = rdata;
        endcase
    end

    // lwr fills the bottom from the addressed lane to lane 3
    always_comb begin
        case (addr_low)
            2'd0:    lwr_val = rdata;
            2'd1:    lwr_val = {rt[31:24], rdata[31:8]};
            2'd2:    lwr_val = {rt[31:16], rdata[31:16]};
            default: lwr_val = {rt[31:8], rdata[31:24]};
        endcase
    end

    always_comb begin
        case (op)
            OP_LB:   result = {{(XLEN-8){byte_val[7]}}, byte_val};
            OP_LBU:  result = {{(XLEN-8){1'b0}}, byte_val};
            OP_LH:   result = {{(XLEN-16){half_val[15]}}, half_val};
            OP_LHU:  result = {{(XLEN-16){1'b0}}, half_val};
            OP_LWL:  result = lwl_val;
            OP_LWR:  result = lwr_val;
            default: result = rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 4;
    localparam int OP_W       = 4;
    localparam int EXCCODE_W  = 5;

    // memory operation codes, zero means no operation
    localparam logic [OP_W-1:0] OP_NOP = 4'd0;

    // loads
    localparam logic [OP_W-1:0] OP_LB  = 4'd1;
    localparam logic [OP_W-1:0] OP_LBU = 4'd2;
    localparam logic [OP_W-1:0] OP_LH  = 4'd3;
    localparam logic [OP_W-1:0] OP_LHU = 4'd4;
    localparam logic [OP_W-1:0] OP_LW  = 4'd5;
    localparam logic [OP_W-1:0] OP_LWL = 4'd6;
    localparam logic [OP_W-1:0] OP_LWR = 4'd7;

    // stores
    localparam logic [OP_W-1:0] OP_SB  = 4'd8;
    localparam logic [OP_W-1:0] OP_SH  = 4'd9;
    localparam logic [OP_W-1:0] OP_SW  = 4'd10;
    localparam logic [OP_W-1:0] OP_SWL = 4'd11;
    localparam logic [OP_W-1:0] OP_SWR = 4'd12;

    // address error codes as in the cp0 cause register
    localparam logic [EXCCODE_W-1:0] EXC_ADEL = 5'd4;
    localparam logic [EXCCODE_W-1:0] EXC_ADES = 5'd5;

endpackage

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  logic [OP_W-1:0]       issue_op,
    input  logic [XLEN-1:0]       issue_base,
    input  logic [15:0]           issue_offset,
    input  logic [XLEN-1:0]       issue_rt,
    input  logic [REG_ADDR_W-1:0] issue_dest,
    input  logic [TAG_W-1:0]      issue_tag,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [3:0]            wb_sel,
    output logic [XLEN-1:0]       wb_adr,
    output logic [XLEN-1:0]       wb_wdata,
    input  logic                  wb_ack,
    input  logic [XLEN-1:0]       wb_rdata,
    output logic                  done_valid,
    input  logic                  done_ready,
    output logic [TAG_W-1:0]      done_tag,
    output logic [REG_ADDR_W-1:0] done_dest,
    output logic                  done_we,
    output logic [XLEN-1:0]       done_result,
    output logic                  done_ex,
    output logic [EXCCODE_W-1:0]  done_exccode,
    output logic [XLEN-1:0]       done_badvaddr
);

    // queue to address stage
    logic                  q_valid, q_ready;
    logic [OP_W-1:0]       q_op;
    logic [XLEN-1:0]       q_base, q_offset_ext, q_rt;
    logic [REG_ADDR_W-1:0] q_dest;
    logic [TAG_W-1:0]      q_tag;

    // address stage to bus master
    logic                  ag_valid, ag_ready;
    logic [OP_W-1:0]       ag_op;
    logic [XLEN-1:0]       ag_addr, ag_wdata, ag_rt;
    logic [3:0]            ag_sel;
    logic [REG_ADDR_W-1:0] ag_dest;
    logic [TAG_W-1:0]      ag_tag;
    logic                  ag_ex;
    logic [EXCCODE_W-1:0]  ag_exccode;

    // bus master to completion
    logic                  bm_valid, bm_ready;
    logic [OP_W-1:0]       bm_op;
    logic [XLEN-1:0]       bm_addr, bm_rt, bm_rdata;
    logic [REG_ADDR_W-1:0] bm_dest;
    logic [TAG_W-1:0]      bm_tag;
    logic                  bm_ex;
    logic [EXCCODE_W-1:0]  bm_exccode;

    // stage ports share the names of the links above
    addr_queue u_addr_queue (.*);

    addr_gen u_addr_gen (.*);

    bus_master u_bus_master (.*);

    result_stage u_result_stage (.*);

endmodule

`default_nettype wire

// ==== rtl/result_stage.sv ====
`default_nettype none

module result_stage import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bm_valid,
    output logic                  bm_ready,
    input  logic [OP_W-1:0]       bm_op,
    input  logic [XLEN-1:0]       bm_addr,
    input  logic [XLEN-1:0]       bm_rt,
    input  logic [XLEN-1:0]       bm_rdata,
    input  logic [REG_ADDR_W-1:0] bm_dest,
    input  logic [TAG_W-1:0]      bm_tag,
    input  logic                  bm_ex,
    input  logic [EXCCODE_W-1:0]  bm_exccode,
    output logic                  done_valid,
    input  logic                  done_ready,
    output logic [TAG_W-1:0]      done_tag,
    output logic [REG_ADDR_W-1:0] done_dest,
    output logic                  done_we,
    output logic [XLEN-1:0]       done_result,
    output logic                  done_ex,
    output logic [EXCCODE_W-1:0]  done_exccode,
    output logic [XLEN-1:0]       done_badvaddr
);

    logic            is_load;
    logic            wr_reg;
    logic [XLEN-1:0] aligned;

    assign is_load  = bm_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign wr_reg   = is_load && !bm_ex;
    assign bm_ready = !done_valid || done_ready;

    load_align u_load_align (
        .op       (bm_op),
        .addr_low (bm_addr[1:0]),
        .rdata    (bm_rdata),
        .rt       (bm_rt),
        .result   (aligned)
    );

    always_ff @(posedge clk) begin
        if (reset)
            done_valid <= 1'b0;
        else if (bm_ready)
            done_valid <= bm_valid;
    end

    // fields only change on a transfer, held while done_ready is low
    always_ff @(posedge clk) begin
        if (bm_valid && bm_ready) begin
            done_tag      <= bm_tag;
            done_dest     <= bm_dest;
            done_we       <= wr_reg;
            done_result   <= wr_reg ? aligned : '0;
            done_ex       <= bm_ex;
            done_exccode  <= bm_exccode;
            done_badvaddr <= bm_ex ? bm_addr : '0;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f compile.f -o lsu_sim

out=$(./obj_dir/lsu_sim)
echo "$out"
grep -qx "TESTS PASSED" <<< "$out"
